// ==== common/autotest_pkg.sv ====
// Shared definitions for the SD-card self-test sequencer.
// Holds the SD block constants, the byte layout of a test vector and of
// the failure record written back to the card, the payload types and the
// grouped control signals between the sequencer, the store and the SPI host.
// Modules take what they need with a wildcard import in their header.

package autotest_pkg;

  // SD card constants
  localparam int block_bytes = 512;
  localparam logic [31:0] first_block = 32'h100000;
  localparam logic [31:0] vector_signature = 32'haabbccdd;

  // UUT run time limit in clock cycles
  localparam int exec_limit = 1000;

  // byte offsets within a block, read vector and write-back record
  localparam int sig_ofs = 0;
  localparam int opa_ofs = 4;
  localparam int opb_ofs = 8;
  localparam int exp_ofs = 10;
  localparam int res_ofs = 13;
  localparam int time_ofs = 16;
  localparam int record_end = 20;

  // payloads, deliberately of different widths
  typedef logic [31:0] operand_a_t;
  typedef logic [15:0] operand_b_t;
  typedef logic [23:0] result_t;

  // byte position within a block, needs to reach block_bytes
  typedef logic [9:0] byte_count_t;

  // command levels to the SPI host
  typedef struct packed {
    logic host_rst;
    logic r_block;
    logic r_byte;
    logic w_block;
    logic w_byte;
  } spi_cmd_t;

  // sequencer to vector store
  typedef struct packed {
    logic        clear;
    logic        load;
    byte_count_t byte_pos;
    logic        capture_result;
  } store_ctrl_t;

endpackage

// ==== logic/field_capture.sv ====
// Byte-wise loadable register for one payload type.
// Each bit of the byte enable writes one byte lane, bit 0 being the least
// significant lane. The field type sets the number of lanes. Used by the
// vector store for the signature, the operands and the expected result.

`timescale 1ns/100ps

module field_capture #(
  parameter type field_t = logic [7:0]
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clear_i,
  input  logic [$bits(field_t)/8-1:0] byte_en_i,
  input  logic [7:0]                  byte_i,
  output field_t                      value_o
);

  logic [$bits(field_t)-1:0] value_q;

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      value_q <= '0;
    end else begin
      for (int i = 0; i < $bits(byte_en_i); i++) begin
        if (byte_en_i[i]) begin
          value_q[8*i +: 8] <= byte_i;
        end
      end
    end
  end

  assign value_o = field_t'(value_q);

endmodule

// ==== logic/run_timer.sv ====
// Execution cycle counter for one UUT run.
// Counts while run_i is high and stops one past the limit, so a run that
// never ends reports exactly exec_limit+1 cycles. run_done_o flags the end
// of the run: UUT end, UUT error or timeout, only while running.

`timescale 1ns/100ps

module run_timer
  import autotest_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_i,
  input  logic        run_i,
  input  logic        uut_end_i,
  input  logic        uut_err_i,
  output logic        run_done_o,
  output logic [31:0] exec_cycles_o
);

  logic [31:0] count_q;
  logic        timeout;

  assign timeout = (count_q > 32'(exec_limit));

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      count_q <= '0;
    end else if (run_i && !timeout) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign run_done_o = run_i && (uut_end_i || uut_err_i || timeout);
  assign exec_cycles_o = count_q;

endmodule

// ==== autotest/sd_sequencer.sv ====
// Control FSM of the self-test sequencer.
// Resets the SPI host, then per block: reads 512 bytes into the vector
// store, checks the signature, runs the UUT under the timer, compares the
// result and on a failure writes the record back over the same block.
// Owns the byte counter, the block address and the error counter.
// A bad signature parks the FSM in the halt state.

`timescale 1ns/100ps

module sd_sequencer
  import autotest_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output spi_cmd_t    spi_cmd_o,
  input  logic        spi_busy_i,
  output logic [31:0] spi_block_addr_o,
  output store_ctrl_t store_o,
  input  logic        sig_ok_i,
  input  logic        result_match_i,
  input  logic        uut_err_i,
  output logic        run_o,
  output logic        timer_clear_o,
  input  logic        run_done_i,
  output logic        uut_rst_o,
  output logic [31:0] err_count_o,
  output logic        halted_o
);

  typedef enum logic [4:0] {
    S_HOST_RST,
    S_HOST_WAIT,
    S_CLEAR,
    S_RD_BLOCK,
    S_RD_BLOCK_WAIT,
    S_RD_BYTE,
    S_RD_BYTE_WAIT,
    S_RD_LOAD,
    S_CHECK,
    S_START,
    S_RUN,
    S_CAPTURE,
    S_COMPARE,
    S_WR_BLOCK,
    S_WR_BLOCK_WAIT,
    S_WR_BYTE,
    S_WR_BYTE_WAIT,
    S_WR_NEXT,
    S_NEXT,
    S_HALT
  } state_t;

  state_t      state_q;
  state_t      state_d;
  byte_count_t byte_cnt_q;
  logic [31:0] block_addr_q;
  logic [31:0] err_count_q;
  logic        err_seen_q;
  logic        fail;

  // a mismatch or an error raised during the run
  assign fail = !result_match_i || err_seen_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_HOST_RST:      if (spi_busy_i) state_d = S_HOST_WAIT;
      S_HOST_WAIT:     if (!spi_busy_i) state_d = S_CLEAR;
      S_CLEAR:         if (!spi_busy_i) state_d = S_RD_BLOCK;
      S_RD_BLOCK:      if (spi_busy_i) state_d = S_RD_BLOCK_WAIT;
      S_RD_BLOCK_WAIT: if (!spi_busy_i) state_d = S_RD_BYTE;
      S_RD_BYTE:       if (spi_busy_i) state_d = S_RD_BYTE_WAIT;
      S_RD_BYTE_WAIT:  if (!spi_busy_i) state_d = S_RD_LOAD;
      S_RD_LOAD: begin
        if (byte_cnt_q == byte_count_t'(block_bytes - 1)) begin
          state_d = S_CHECK;
        end else begin
          state_d = S_RD_BYTE;
        end
      end
      S_CHECK:         state_d = sig_ok_i ? S_START : S_HALT;
      S_START:         state_d = S_RUN;
      S_RUN:           if (run_done_i) state_d = S_CAPTURE;
      S_CAPTURE:       state_d = S_COMPARE;
      S_COMPARE:       state_d = fail ? S_WR_BLOCK : S_NEXT;
      S_WR_BLOCK:      if (spi_busy_i) state_d = S_WR_BLOCK_WAIT;
      S_WR_BLOCK_WAIT: if (!spi_busy_i) state_d = S_WR_BYTE;
      S_WR_BYTE:       if (spi_busy_i) state_d = S_WR_BYTE_WAIT;
      S_WR_BYTE_WAIT:  if (!spi_busy_i) state_d = S_WR_NEXT;
      // one cycle for the store to register the next write byte
      S_WR_NEXT: begin
        if (byte_cnt_q == byte_count_t'(block_bytes)) begin
          state_d = S_NEXT;
        end else begin
          state_d = S_WR_BYTE;
        end
      end
      S_NEXT:          state_d = S_CLEAR;
      S_HALT:          state_d = S_HALT;
      default:         state_d = S_HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_HOST_RST;
      byte_cnt_q <= '0;
      block_addr_q <= first_block;
      err_count_q <= '0;
      err_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      case (state_q)
        S_CLEAR: byte_cnt_q <= '0;
        S_RD_LOAD: byte_cnt_q <= byte_cnt_q + 1'b1;
        S_START: err_seen_q <= 1'b0;
        S_RUN: begin
          if (uut_err_i) begin
            err_seen_q <= 1'b1;
          end
        end
        S_COMPARE: begin
          byte_cnt_q <= '0;
          if (fail) begin
            err_count_q <= err_count_q + 32'd1;
          end
        end
        S_WR_BYTE_WAIT: begin
          if (!spi_busy_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
        end
        S_NEXT: block_addr_q <= block_addr_q + 32'd1;
        default: ;
      endcase
    end
  end

  // outputs decoded from the state
  always_comb begin
    spi_cmd_o = '0;
    store_o = '0;
    store_o.byte_pos = byte_cnt_q;
    run_o = 1'b0;
    timer_clear_o = 1'b0;
    uut_rst_o = 1'b1;
    case (state_q)
      S_HOST_RST: spi_cmd_o.host_rst = 1'b1;
      S_CLEAR: begin
        store_o.clear = 1'b1;
        timer_clear_o = 1'b1;
      end
      S_RD_BLOCK, S_RD_BLOCK_WAIT, S_RD_BYTE_WAIT: spi_cmd_o.r_block = 1'b1;
      S_RD_BYTE: begin
        spi_cmd_o.r_block = 1'b1;
        spi_cmd_o.r_byte = 1'b1;
      end
      S_RD_LOAD: begin
        spi_cmd_o.r_block = 1'b1;
        store_o.load = 1'b1;
      end
      S_START: uut_rst_o = 1'b0;
      S_RUN: begin
        uut_rst_o = 1'b0;
        run_o = 1'b1;
      end
      S_CAPTURE: store_o.capture_result = 1'b1;
      S_WR_BLOCK, S_WR_BLOCK_WAIT, S_WR_BYTE_WAIT, S_WR_NEXT: spi_cmd_o.w_block = 1'b1;
      S_WR_BYTE: begin
        spi_cmd_o.w_block = 1'b1;
        spi_cmd_o.w_byte = 1'b1;
      end
      default: ;
    endcase
  end

  assign spi_block_addr_o = block_addr_q;
  assign err_count_o = err_count_q;
  assign halted_o = (state_q == S_HALT);

endmodule

// ==== autotest/vector_store.sv ====
// Vector store for the self-test sequencer.
// Captures the bytes of a block read into the signature, operand and
// expected result fields by their position in the layout. The signature
// arrives big-endian, the other fields least significant byte first.
// Records the UUT result and run time at test end and serves the
// write-back record byte by byte, ff past the record, as SPI write data.

`timescale 1ns/100ps

module vector_store
  import autotest_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  store_ctrl_t store_i,
  input  logic [7:0]  rdata_i,
  input  result_t     result_i,
  input  logic [31:0] exec_cycles_i,
  output operand_a_t  operand_a_o,
  output operand_b_t  operand_b_o,
  output logic        sig_ok_o,
  output logic        result_match_o,
  output logic [7:0]  wr_byte_o
);

  typedef logic [31:0] signature_t;

  signature_t                         sig_q;
  result_t                            exp_q;
  result_t                            result_q;
  logic [31:0]                        exec_q;
  logic [$bits(signature_t)/8-1:0]    sig_en;
  logic [$bits(operand_a_t)/8-1:0]    opa_en;
  logic [$bits(operand_b_t)/8-1:0]    opb_en;
  logic [$bits(result_t)/8-1:0]       exp_en;
  logic [7:0]                         wr_next;
  logic [7:0]                         wr_byte_q;

  // byte lane enables from the read position
  always_comb begin
    sig_en = '0;
    opa_en = '0;
    opb_en = '0;
    exp_en = '0;
    if (store_i.load) begin
      for (int k = 0; k < $bits(sig_en); k++) begin
        sig_en[$bits(sig_en)-1-k] = (store_i.byte_pos == byte_count_t'(sig_ofs + k));
      end
      for (int k = 0; k < $bits(opa_en); k++) begin
        opa_en[k] = (store_i.byte_pos == byte_count_t'(opa_ofs + k));
      end
      for (int k = 0; k < $bits(opb_en); k++) begin
        opb_en[k] = (store_i.byte_pos == byte_count_t'(opb_ofs + k));
      end
      for (int k = 0; k < $bits(exp_en); k++) begin
        exp_en[k] = (store_i.byte_pos == byte_count_t'(exp_ofs + k));
      end
    end
  end

  field_capture #(.field_t(signature_t)) sig_field_i (
    .clk(clk), .rst(rst), .clear_i(store_i.clear),
    .byte_en_i(sig_en), .byte_i(rdata_i), .value_o(sig_q)
  );

  field_capture #(.field_t(operand_a_t)) opa_field_i (
    .clk(clk), .rst(rst), .clear_i(store_i.clear),
    .byte_en_i(opa_en), .byte_i(rdata_i), .value_o(operand_a_o)
  );

  field_capture #(.field_t(operand_b_t)) opb_field_i (
    .clk(clk), .rst(rst), .clear_i(store_i.clear),
    .byte_en_i(opb_en), .byte_i(rdata_i), .value_o(operand_b_o)
  );

  field_capture #(.field_t(result_t)) exp_field_i (
    .clk(clk), .rst(rst), .clear_i(store_i.clear),
    .byte_en_i(exp_en), .byte_i(rdata_i), .value_o(exp_q)
  );

  always_ff @(posedge clk) begin
    if (store_i.capture_result) begin
      result_q <= result_i;
      exec_q <= exec_cycles_i;
    end
  end

  assign sig_ok_o = (sig_q == vector_signature);
  assign result_match_o = (result_q == exp_q);

  // write-back byte in record order
  always_comb begin
    int pos;
    pos = int'(store_i.byte_pos);
    wr_next = 8'hff;
    if (pos < opa_ofs) begin
      wr_next = sig_q[8*(opa_ofs-1-pos) +: 8];
    end else if (pos < opb_ofs) begin
      wr_next = operand_a_o[8*(pos-opa_ofs) +: 8];
    end else if (pos < exp_ofs) begin
      wr_next = operand_b_o[8*(pos-opb_ofs) +: 8];
    end else if (pos < res_ofs) begin
      wr_next = exp_q[8*(pos-exp_ofs) +: 8];
    end else if (pos < time_ofs) begin
      wr_next = result_q[8*(pos-res_ofs) +: 8];
    end else if (pos < record_end) begin
      wr_next = exec_q[8*(pos-time_ofs) +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_byte_q <= 8'hff;
    end else begin
      wr_byte_q <= wr_next;
    end
  end

  assign wr_byte_o = wr_byte_q;

endmodule

// ==== logic/autotest_top.sv ====
// Top level of the SD-card self-test sequencer.
// Connects the control FSM, the vector store and the run timer. The SPI
// host and the UUT sit outside; the store drives the UUT operands and the
// SPI write data, the FSM drives the SPI commands and the UUT reset.

`timescale 1ns/100ps

module autotest_top
  import autotest_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output spi_cmd_t    spi_cmd_o,
  input  logic        spi_busy_i,
  input  logic [7:0]  spi_rdata_i,
  output logic [7:0]  spi_wdata_o,
  output logic [31:0] spi_block_addr_o,
  output logic        uut_rst_o,
  input  logic        uut_end_i,
  input  logic        uut_err_i,
  output operand_a_t  operand_a_o,
  output operand_b_t  operand_b_o,
  input  result_t     result_i,
  output logic [31:0] err_count_o,
  output logic        halted_o
);

  store_ctrl_t store_ctrl;
  logic        sig_ok;
  logic        result_match;
  logic        run;
  logic        timer_clear;
  logic        run_done;
  logic [31:0] exec_cycles;

  sd_sequencer sequencer_i (
    .clk(clk),
    .rst(rst),
    .spi_cmd_o(spi_cmd_o),
    .spi_busy_i(spi_busy_i),
    .spi_block_addr_o(spi_block_addr_o),
    .store_o(store_ctrl),
    .sig_ok_i(sig_ok),
    .result_match_i(result_match),
    .uut_err_i(uut_err_i),
    .run_o(run),
    .timer_clear_o(timer_clear),
    .run_done_i(run_done),
    .uut_rst_o(uut_rst_o),
    .err_count_o(err_count_o),
    .halted_o(halted_o)
  );

  vector_store store_i (
    .clk(clk),
    .rst(rst),
    .store_i(store_ctrl),
    .rdata_i(spi_rdata_i),
    .result_i(result_i),
    .exec_cycles_i(exec_cycles),
    .operand_a_o(operand_a_o),
    .operand_b_o(operand_b_o),
    .sig_ok_o(sig_ok),
    .result_match_o(result_match),
    .wr_byte_o(spi_wdata_o)
  );

  run_timer timer_i (
    .clk(clk),
    .rst(rst),
    .clear_i(timer_clear),
    .run_i(run),
    .uut_end_i(uut_end_i),
    .uut_err_i(uut_err_i),
    .run_done_o(run_done),
    .exec_cycles_o(exec_cycles)
  );

endmodule

// ==== testbench/sd_card_model.sv ====
// Behavioral SPI host plus SD card for the self-test sequencer testbench.
// Answers each command level with busy after a short random delay, serves
// read bytes from a block memory and captures written blocks. The testbench
// preloads blocks with load_block and inspects the write log directly.

`timescale 1ns/100ps

module sd_card_model
  import autotest_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  spi_cmd_t    spi_cmd_i,
  output logic        busy_o,
  output logic [7:0]  rdata_o,
  input  logic [7:0]  wdata_i,
  input  logic [31:0] block_addr_i
);

  typedef enum {M_IDLE, M_DELAY, M_BUSY} model_state_t;
  typedef enum {K_HOST, K_RD_OPEN, K_RD_BYTE, K_WR_OPEN, K_WR_BYTE} kind_t;

  // block memory keyed by block address and byte index
  logic [7:0]   mem [logic [41:0]];
  logic [7:0]   wr_buf [block_bytes];
  logic [7:0]   last_wr [block_bytes];
  logic [31:0]  last_wr_addr;
  int           wr_count;
  int           wr_len;
  int           cmd_count;
  model_state_t m_state;
  kind_t        kind;
  int           delay_cnt;
  int           busy_cnt;
  int           rd_idx;
  int           wr_idx;
  logic         rd_open;
  logic         wr_open;
  logic [31:0]  lfsr = 32'h12d7_5cd4;

  // quiet bus until the first clock edge
  initial begin
    busy_o = 1'b0;
    rdata_o = 8'h00;
  end

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic load_block(input logic [31:0] addr, input logic [7:0] data [block_bytes]);
    for (int i = 0; i < block_bytes; i++) begin
      mem[{addr, 10'(i)}] = data[i];
    end
  endtask

  function automatic logic [7:0] read_byte(input logic [31:0] addr, input int idx);
    if (mem.exists({addr, 10'(idx)})) begin
      return mem[{addr, 10'(idx)}];
    end
    return 8'h00;
  endfunction

  task automatic start(input kind_t k);
    kind = k;
    delay_cnt = int'(next_bits(1));
    busy_cnt = int'(next_bits(2)) + 1;
    cmd_count++;
    m_state = M_DELAY;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      m_state = M_IDLE;
      rd_open = 1'b0;
      wr_open = 1'b0;
      wr_count = 0;
      cmd_count = 0;
      busy_o <= 1'b0;
      rdata_o <= 8'h00;
    end else begin
      case (m_state)
        M_IDLE: begin
          if (rd_open && !spi_cmd_i.r_block) begin
            rd_open = 1'b0;
          end
          if (wr_open && !spi_cmd_i.w_block) begin
            // block write finished, log it
            wr_open = 1'b0;
            last_wr_addr = block_addr_i;
            last_wr = wr_buf;
            wr_len = wr_idx;
            for (int i = 0; i < wr_idx; i++) begin
              mem[{block_addr_i, 10'(i)}] = wr_buf[i];
            end
            wr_count++;
          end
          if (spi_cmd_i.host_rst) begin
            start(K_HOST);
          end else if (spi_cmd_i.r_byte && rd_open) begin
            start(K_RD_BYTE);
          end else if (spi_cmd_i.r_block && !rd_open) begin
            start(K_RD_OPEN);
          end else if (spi_cmd_i.w_byte && wr_open) begin
            if (wr_idx < block_bytes) begin
              wr_buf[wr_idx] = wdata_i;
            end
            start(K_WR_BYTE);
          end else if (spi_cmd_i.w_block && !wr_open) begin
            start(K_WR_OPEN);
          end
        end
        M_DELAY: begin
          if (delay_cnt == 0) begin
            busy_o <= 1'b1;
            m_state = M_BUSY;
          end else begin
            delay_cnt--;
          end
        end
        default: begin
          if (busy_cnt <= 1) begin
            busy_o <= 1'b0;
            m_state = M_IDLE;
            case (kind)
              K_RD_OPEN: begin
                rd_open = 1'b1;
                rd_idx = 0;
              end
              K_RD_BYTE: begin
                rdata_o <= read_byte(block_addr_i, rd_idx);
                rd_idx++;
              end
              K_WR_OPEN: begin
                wr_open = 1'b1;
                wr_idx = 0;
              end
              K_WR_BYTE: wr_idx++;
              default: ;
            endcase
          end else begin
            busy_cnt--;
          end
        end
      endcase
    end
  end

endmodule

// ==== testbench/tb_autotest.sv ====
// Testbench for the SD-card self-test sequencer.
// Runs directed checks through autotest_top with an SD card model and a
// simple UUT model: the values after reset, a passing vector, a wrong
// result, a UUT error, a timeout and a bad signature. Ends with a summary line.

`timescale 1ns/100ps

module tb_autotest
  import autotest_pkg::*;
();

  localparam int num_vectors = 5;
  localparam int num_tests = num_vectors + 1;
  localparam int cycle_limit = num_vectors * (2 * block_bytes * 8 + exec_limit + 200) + 200;

  logic        clk;
  logic        rst;
  spi_cmd_t    spi_cmd;
  logic        spi_busy;
  logic [7:0]  spi_rdata;
  logic [7:0]  spi_wdata;
  logic [31:0] block_addr;
  logic        uut_rst;
  logic        uut_end;
  logic        uut_err;
  operand_a_t  operand_a;
  operand_b_t  operand_b;
  result_t     result;
  logic [31:0] err_count;
  logic        halted;

  // UUT model settings and observations
  result_t     uut_result;
  int          uut_delay;
  logic        uut_hang;
  logic        uut_raise_err;
  int          uut_cnt;
  operand_a_t  seen_a;
  operand_b_t  seen_b;
  logic        ops_moved;

  int          errors;
  int          failed_tests;
  int          cycles;
  logic [31:0] lfsr = 32'h12d7_5cd4;

  autotest_top dut_i (
    .clk(clk), .rst(rst), .spi_cmd_o(spi_cmd), .spi_busy_i(spi_busy),
    .spi_rdata_i(spi_rdata), .spi_wdata_o(spi_wdata), .spi_block_addr_o(block_addr),
    .uut_rst_o(uut_rst), .uut_end_i(uut_end), .uut_err_i(uut_err),
    .operand_a_o(operand_a), .operand_b_o(operand_b), .result_i(result),
    .err_count_o(err_count), .halted_o(halted)
  );

  sd_card_model card_i (
    .clk(clk), .rst(rst), .spi_cmd_i(spi_cmd), .busy_o(spi_busy),
    .rdata_o(spi_rdata), .wdata_i(spi_wdata), .block_addr_i(block_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no progress within %0d cycles", cycle_limit);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // UUT: ends after uut_delay run cycles unless told to hang
  always @(negedge clk) begin
    if (rst || uut_rst) begin
      uut_cnt = 0;
      uut_end = 1'b0;
      uut_err = 1'b0;
    end else begin
      if (uut_cnt == 0) begin
        seen_a = operand_a;
        seen_b = operand_b;
      end else if (operand_a !== seen_a || operand_b !== seen_b) begin
        ops_moved = 1'b1;
      end
      uut_cnt++;
      if (!uut_hang && uut_cnt >= uut_delay) begin
        uut_end = 1'b1;
        uut_err = uut_raise_err;
        result = uut_result;
      end
    end
  end

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("Error: %s = %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    if (errors == err_start) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s", name);
      failed_tests++;
    end
  endtask

  task automatic reset_values();
    spi_cmd_t want_cmd;
    int       err_start;
    want_cmd = '0;
    want_cmd.host_rst = 1'b1;
    err_start = errors;
    expect_eq("spi_cmd_o", {27'd0, spi_cmd}, {27'd0, want_cmd});
    expect_eq("uut_rst_o", 32'(uut_rst), 32'd1);
    expect_eq("halted_o", 32'(halted), 32'd0);
    expect_eq("err_count_o", err_count, 32'd0);
    expect_eq("spi_block_addr_o", block_addr, first_block);
    finish_test("reset values", err_start);
  endtask

  task automatic run_vector(input string name, input logic [31:0] sig, input logic wrong,
                            input logic raise_err, input logic hang);
    logic [7:0]  blk [block_bytes];
    logic [7:0]  rec [block_bytes];
    logic [31:0] addr;
    logic [31:0] err0;
    logic [31:0] exec_t;
    operand_a_t  a;
    operand_b_t  b;
    result_t     exp;
    int          wr0;
    int          cmd_h;
    int          err_start;
    err_start = errors;
    a = rand_bits(32);
    b = operand_b_t'(rand_bits(16));
    exp = result_t'(rand_bits(24));
    addr = block_addr;
    for (int i = 0; i < block_bytes; i++) begin
      blk[i] = 8'(i) ^ 8'(i >> 8) ^ addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h3c;
    end
    for (int k = 0; k < 4; k++) begin
      blk[sig_ofs + k] = sig[8*(3-k) +: 8];
      blk[opa_ofs + k] = a[8*k +: 8];
    end
    for (int k = 0; k < 2; k++) begin
      blk[opb_ofs + k] = b[8*k +: 8];
    end
    for (int k = 0; k < 3; k++) begin
      blk[exp_ofs + k] = exp[8*k +: 8];
    end
    card_i.load_block(addr, blk);
    uut_result = wrong ? (exp ^ 24'h5a_0001) : exp;
    uut_delay = 5 + int'(rand_bits(4));
    uut_hang = hang;
    uut_raise_err = raise_err;
    ops_moved = 1'b0;
    err0 = err_count;
    wr0 = card_i.wr_count;
    while (block_addr == addr && !halted) begin
      @(negedge clk);
    end
    expect_eq("uut_rst_o", 32'(uut_rst), 32'd1);
    if (sig != vector_signature) begin
      expect_eq("halted_o", 32'(halted), 32'd1);
      cmd_h = card_i.cmd_count;
      repeat (100) @(negedge clk);
      if (card_i.cmd_count != cmd_h || spi_cmd != '0) begin
        $display("SPI command issued after halt");
        errors++;
      end
      expect_eq("spi_block_addr_o", block_addr, addr);
      expect_eq("err_count_o", err_count, err0);
    end else begin
      expect_eq("halted_o", 32'(halted), 32'd0);
      expect_eq("spi_block_addr_o", block_addr, addr + 32'd1);
      expect_eq("operand_a_o", seen_a, a);
      expect_eq("operand_b_o", 32'(seen_b), 32'(b));
      if (ops_moved) begin
        $display("Operands changed while the UUT was running");
        errors++;
      end
      if (wrong || raise_err || hang) begin
        expect_eq("err_count_o", err_count, err0 + 32'd1);
        expect_eq("written blocks", card_i.wr_count, wr0 + 1);
        expect_eq("written block address", card_i.last_wr_addr, addr);
        expect_eq("written length", card_i.wr_len, block_bytes);
        for (int i = 0; i < block_bytes; i++) begin
          rec[i] = (i < res_ofs) ? blk[i] : 8'hff;
        end
        // a hung UUT leaves its previous result on result_i
        for (int k = 0; k < 3; k++) begin
          rec[res_ofs + k] = hang ? result[8*k +: 8] : uut_result[8*k +: 8];
        end
        for (int k = 0; k < 4; k++) begin
          exec_t[8*k +: 8] = card_i.last_wr[time_ofs + k];
        end
        // exec time bytes are checked as a value below
        for (int i = 0; i < block_bytes; i++) begin
          if (i < time_ofs || i >= record_end) begin
            expect_eq($sformatf("written byte %0d", i), 32'(card_i.last_wr[i]), 32'(rec[i]));
          end
        end
        if (hang) begin
          expect_eq("exec time", exec_t, 32'(exec_limit + 1));
        end else if (exec_t > 32'(exec_limit)) begin
          $display("Error: exec time = %h, limit %h", exec_t, 32'(exec_limit));
          errors++;
        end
      end else begin
        expect_eq("err_count_o", err_count, err0);
        expect_eq("written blocks", card_i.wr_count, wr0);
      end
    end
    finish_test(name, err_start);
  endtask

  task automatic passing_vector();
    run_vector("passing vector", vector_signature, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wrong_result();
    run_vector("wrong result", vector_signature, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic uut_error_vector();
    run_vector("uut error", vector_signature, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic timeout_vector();
    run_vector("timeout", vector_signature, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic bad_signature();
    run_vector("bad signature", 32'h1234_5678, 1'b0, 1'b0, 1'b0);
  endtask

  initial begin
    rst = 1'b1;
    uut_end = 1'b0;
    uut_err = 1'b0;
    result = '0;
    uut_result = '0;
    uut_delay = 1;
    uut_hang = 1'b0;
    uut_raise_err = 1'b0;
    ops_moved = 1'b0;
    errors = 0;
    failed_tests = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    reset_values();
    passing_vector();
    wrong_result();
    uut_error_vector();
    timeout_vector();
    bad_signature();
    $display("%0d tests run, %0d failed, %0d check errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/autotest_pkg.sv
logic/field_capture.sv
logic/run_timer.sv
autotest/sd_sequencer.sv
autotest/vector_store.sv
logic/autotest_top.sv
testbench/sd_card_model.sv
testbench/tb_autotest.sv
